//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Address and data widths.
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned INST_W = 32;

  // Cache geometry: 4 sets of two words.
  localparam int unsigned SET_BITS = 2;
  localparam int unsigned SETS = 2 ** SET_BITS;
  localparam int unsigned OFS_BITS = 1;
  localparam int unsigned TAG_W = ADDR_W - SET_BITS - OFS_BITS - 2;

  // First instruction after reset.
  localparam logic [ADDR_W-1:0] PC_INIT = 32'h8000_0000;

  // fence.i with all fields zero.
  localparam logic [INST_W-1:0] INST_FENCE_I = 32'h0000_100f;

  // RV32 major opcodes that the predecoder cares about.
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // Line refill sequence.
  typedef enum logic [2:0] {
    RF_IDLE,
    RF_LO,
    RF_GAP,
    RF_HI,
    RF_DONE
  } refill_state_e;

  // Fetch either runs or waits on the backend.
  typedef enum logic {
    FS_RUN,
    FS_STALL
  } fetch_state_e;

endpackage

`default_nettype wire

//--- icache_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_store
  import fetch_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic [ADDR_W-1:0]   lookup_pc_i,
  input  wire logic                flush_i,
  input  wire logic                wr_en_i,
  input  wire logic [OFS_BITS-1:0] wr_ofs_i,
  input  wire logic [INST_W-1:0]   wr_data_i,
  input  wire logic [TAG_W-1:0]    wr_tag_i,
  input  wire logic                wr_valid_i,
  output logic                     hit_o,
  output logic [INST_W-1:0]        hit_inst_o
);

  logic [INST_W-1:0]   data_q [SETS][2**OFS_BITS];
  logic [TAG_W-1:0]    tag_q [SETS];
  logic [SETS-1:0]     valid_q;

  logic [TAG_W-1:0]    pc_tag;
  logic [SET_BITS-1:0] pc_set;
  logic [OFS_BITS-1:0] pc_ofs;

  // Address split: tag, set, word offset, byte.
  assign pc_tag = lookup_pc_i[ADDR_W-1 -: TAG_W];
  assign pc_set = lookup_pc_i[OFS_BITS+2 +: SET_BITS];
  assign pc_ofs = lookup_pc_i[2 +: OFS_BITS];

  assign hit_o      = valid_q[pc_set] && (tag_q[pc_set] == pc_tag);
  assign hit_inst_o = data_q[pc_set][pc_ofs];

  // The first word of a refill drops the old line, the last one validates it.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[pc_set] <= wr_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      data_q[pc_set][wr_ofs_i] <= wr_data_i;
      tag_q[pc_set]            <= wr_tag_i;
    end
  end

  // A flush only follows an accepted fence.i, never in the middle of a refill.
  a_no_write_on_flush : assert property (
    @(posedge clk) disable iff (rst)
    !(wr_en_i && flush_i)
  );

endmodule

`default_nettype wire

//--- icache_refill.sv
`timescale 1ns/100ps
`default_nettype none

module icache_refill
  import fetch_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                miss_i,
  input  wire logic [ADDR_W-1:0]   pc_i,
  input  wire logic [INST_W-1:0]   ifu_rdata_i,
  input  wire logic                ifu_rvalid_i,
  output logic [ADDR_W-1:0]        ifu_araddr_o,
  output logic                     ifu_arvalid_o,
  output logic                     ifu_busy_o,
  output logic                     wr_en_o,
  output logic [OFS_BITS-1:0]      wr_ofs_o,
  output logic [INST_W-1:0]        wr_data_o,
  output logic [TAG_W-1:0]         wr_tag_o,
  output logic                     wr_valid_o
);

  refill_state_e state_q;

  // Line address of the refill in flight.
  logic [TAG_W+SET_BITS-1:0] line_q;
  logic                      line_match;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
    end else begin
      case (state_q)
        RF_IDLE: begin
          if (miss_i) begin
            state_q <= RF_LO;
          end
        end
        RF_LO: begin
          if (ifu_rvalid_i) begin
            state_q <= RF_GAP;
          end
        end
        RF_GAP: begin
          state_q <= RF_HI;
        end
        RF_HI: begin
          if (ifu_rvalid_i) begin
            state_q <= RF_DONE;
          end
        end
        RF_DONE: begin
          state_q <= RF_IDLE;
        end
        default: begin
          state_q <= RF_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE && miss_i) begin
      line_q <= pc_i[ADDR_W-1:OFS_BITS+2];
    end
  end

  assign ifu_arvalid_o = (state_q == RF_LO) || (state_q == RF_HI);
  assign ifu_busy_o    = (state_q != RF_IDLE);
  assign wr_ofs_o      = (state_q == RF_HI) ? OFS_BITS'(1) : '0;
  assign ifu_araddr_o  = {line_q, wr_ofs_o, 2'b00};

  // A redirect mid-refill moves the store's set, so late words are dropped.
  assign line_match = (pc_i[ADDR_W-1:OFS_BITS+2] == line_q);

  assign wr_en_o    = ifu_arvalid_o && ifu_rvalid_i && line_match;
  assign wr_data_o  = ifu_rdata_i;
  assign wr_tag_o   = line_q[TAG_W+SET_BITS-1:SET_BITS];
  assign wr_valid_o = (state_q == RF_HI);

  // Bus request holds until the data returns.
  a_addr_stable : assert property (
    @(posedge clk) disable iff (rst)
    ifu_arvalid_o && !ifu_rvalid_i |=> ifu_arvalid_o && $stable(ifu_araddr_o)
  );

endmodule

`default_nettype wire

//--- fetch_btb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_btb
  import fetch_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic [ADDR_W-1:0] query_pc_i,
  input  wire logic              learn_i,
  input  wire logic [ADDR_W-1:0] learn_pc_i,
  input  wire logic [ADDR_W-1:0] learn_target_i,
  input  wire logic              spec_start_i,
  input  wire logic              prev_valid_i,
  input  wire logic [ADDR_W-1:0] npc_i,
  output logic                   predict_hit_o,
  output logic [ADDR_W-1:0]      predict_target_o,
  output logic                   spec_pending_o,
  output logic                   bad_speculation_o
);

  logic              btb_valid_q;
  logic [ADDR_W-1:0] btb_pc_q;
  logic [ADDR_W-1:0] btb_target_q;

  logic              spec_q;
  logic [ADDR_W-1:0] spec_target_q;

  assign predict_hit_o     = btb_valid_q && (btb_pc_q == query_pc_i);
  assign predict_target_o  = btb_target_q;
  assign spec_pending_o    = spec_q;
  assign bad_speculation_o = prev_valid_i && spec_q && (npc_i != spec_target_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
    end else begin
      if (learn_i) begin
        btb_valid_q <= 1'b1;
      end
      // Next backend report settles the guess either way.
      if (spec_start_i) begin
        spec_q <= 1'b1;
      end else if (prev_valid_i) begin
        spec_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (learn_i) begin
      btb_pc_q     <= learn_pc_i;
      btb_target_q <= learn_target_i;
    end
    if (spec_start_i) begin
      spec_target_q <= btb_target_q;
    end
  end

endmodule

`default_nettype wire

//--- fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl
  import fetch_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              hit_i,
  input  wire logic [INST_W-1:0] hit_inst_i,
  input  wire logic              predict_hit_i,
  input  wire logic [ADDR_W-1:0] predict_target_i,
  input  wire logic              spec_pending_i,
  input  wire logic              bad_speculation_i,
  input  wire logic [ADDR_W-1:0] npc_i,
  input  wire logic              pc_change_i,
  input  wire logic              pc_retire_i,
  input  wire logic              prev_valid_i,
  input  wire logic              next_ready_i,
  output logic [ADDR_W-1:0]      lookup_pc_o,
  output logic                   flush_o,
  output logic                   learn_o,
  output logic [ADDR_W-1:0]      learn_pc_o,
  output logic [ADDR_W-1:0]      learn_target_o,
  output logic                   spec_start_o,
  output logic                   valid_o,
  output logic                   ready_o,
  output logic [INST_W-1:0]      inst_o,
  output logic [ADDR_W-1:0]      pc_o
);

  fetch_state_e      state_q;
  logic              load_stall_q;
  logic              branch_stall_q;
  logic [ADDR_W-1:0] pc_q;

  opcode_e           opcode;
  logic              is_branch;
  logic              is_load;
  logic              is_fence_i;
  logic              accept;
  logic              resolve;

  // Predecode.
  assign opcode     = opcode_e'(hit_inst_i[6:0]);
  assign is_branch  = (opcode == OP_BRANCH) || (opcode == OP_JAL) ||
                      (opcode == OP_JALR) || (opcode == OP_SYSTEM);
  assign is_load    = (opcode == OP_LOAD);
  assign is_fence_i = (hit_inst_i == INST_FENCE_I);

  assign valid_o     = hit_i && (state_q == FS_RUN);
  assign ready_o     = !valid_o;
  assign inst_o      = hit_inst_i;
  assign pc_o        = pc_q;
  assign lookup_pc_o = pc_q;

  assign accept  = valid_o && next_ready_i;
  assign flush_o = accept && is_fence_i;

  // Each stall waits for its own kind of backend report.
  assign resolve = prev_valid_i &&
                   ((load_stall_q && pc_retire_i) || (branch_stall_q && pc_change_i));

  assign spec_start_o = accept && is_branch && predict_hit_i && !spec_pending_i;

  // While branch-stalled the PC is still the branch.
  assign learn_o        = prev_valid_i && pc_change_i && branch_stall_q;
  assign learn_pc_o     = pc_q;
  assign learn_target_o = npc_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= FS_RUN;
      load_stall_q   <= 1'b0;
      branch_stall_q <= 1'b0;
      pc_q           <= PC_INIT;
    end else if (bad_speculation_i || resolve) begin
      state_q        <= FS_RUN;
      load_stall_q   <= 1'b0;
      branch_stall_q <= 1'b0;
      pc_q           <= npc_i;
    end else if (accept) begin
      if (is_branch) begin
        if (spec_start_o) begin
          pc_q <= predict_target_i;
        end else begin
          state_q        <= FS_STALL;
          branch_stall_q <= 1'b1;
        end
      end else if (is_load) begin
        state_q      <= FS_STALL;
        load_stall_q <= 1'b1;
      end else begin
        pc_q <= pc_q + ADDR_W'(4);
      end
    end
  end

  // A pending load or branch stall keeps the output invalid.
  a_stall_blocks_valid : assert property (
    @(posedge clk) disable iff (rst)
    (load_stall_q || branch_stall_q) |-> !valid_o
  );

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  // Read bus.
  output logic [ADDR_W-1:0]      ifu_araddr_o,
  output logic                   ifu_arvalid_o,
  input  wire logic [INST_W-1:0] ifu_rdata_i,
  input  wire logic              ifu_rvalid_i,
  output logic                   ifu_busy_o,
  // Backend.
  input  wire logic [ADDR_W-1:0] npc_i,
  input  wire logic              pc_change_i,
  input  wire logic              pc_retire_i,
  input  wire logic              prev_valid_i,
  input  wire logic              next_ready_i,
  output logic                   valid_o,
  output logic                   ready_o,
  output logic [INST_W-1:0]      inst_o,
  output logic [ADDR_W-1:0]      pc_o,
  output logic                   bad_speculation_o
);

  logic [ADDR_W-1:0]   lookup_pc;
  logic                flush;
  logic                hit;
  logic [INST_W-1:0]   hit_inst;
  logic                wr_en;
  logic [OFS_BITS-1:0] wr_ofs;
  logic [INST_W-1:0]   wr_data;
  logic [TAG_W-1:0]    wr_tag;
  logic                wr_valid;
  logic                predict_hit;
  logic [ADDR_W-1:0]   predict_target;
  logic                spec_pending;
  logic                learn;
  logic [ADDR_W-1:0]   learn_pc;
  logic [ADDR_W-1:0]   learn_target;
  logic                spec_start;

  fetch_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .hit_i             (hit),
    .hit_inst_i        (hit_inst),
    .predict_hit_i     (predict_hit),
    .predict_target_i  (predict_target),
    .spec_pending_i    (spec_pending),
    .bad_speculation_i (bad_speculation_o),
    .npc_i             (npc_i),
    .pc_change_i       (pc_change_i),
    .pc_retire_i       (pc_retire_i),
    .prev_valid_i      (prev_valid_i),
    .next_ready_i      (next_ready_i),
    .lookup_pc_o       (lookup_pc),
    .flush_o           (flush),
    .learn_o           (learn),
    .learn_pc_o        (learn_pc),
    .learn_target_o    (learn_target),
    .spec_start_o      (spec_start),
    .valid_o           (valid_o),
    .ready_o           (ready_o),
    .inst_o            (inst_o),
    .pc_o              (pc_o)
  );

  icache_store u_store (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc_i (lookup_pc),
    .flush_i     (flush),
    .wr_en_i     (wr_en),
    .wr_ofs_i    (wr_ofs),
    .wr_data_i   (wr_data),
    .wr_tag_i    (wr_tag),
    .wr_valid_i  (wr_valid),
    .hit_o       (hit),
    .hit_inst_o  (hit_inst)
  );

  icache_refill u_refill (
    .clk           (clk),
    .rst           (rst),
    .miss_i        (!hit),
    .pc_i          (lookup_pc),
    .ifu_rdata_i   (ifu_rdata_i),
    .ifu_rvalid_i  (ifu_rvalid_i),
    .ifu_araddr_o  (ifu_araddr_o),
    .ifu_arvalid_o (ifu_arvalid_o),
    .ifu_busy_o    (ifu_busy_o),
    .wr_en_o       (wr_en),
    .wr_ofs_o      (wr_ofs),
    .wr_data_o     (wr_data),
    .wr_tag_o      (wr_tag),
    .wr_valid_o    (wr_valid)
  );

  fetch_btb u_btb (
    .clk               (clk),
    .rst               (rst),
    .query_pc_i        (lookup_pc),
    .learn_i           (learn),
    .learn_pc_i        (learn_pc),
    .learn_target_i    (learn_target),
    .spec_start_i      (spec_start),
    .prev_valid_i      (prev_valid_i),
    .npc_i             (npc_i),
    .predict_hit_o     (predict_hit),
    .predict_target_o  (predict_target),
    .spec_pending_o    (spec_pending),
    .bad_speculation_o (bad_speculation_o)
  );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model
  import fetch_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic [ADDR_W-1:0] araddr_i,
  input  wire logic              arvalid_i,
  output logic [INST_W-1:0]      rdata_o,
  output logic                   rvalid_o,
  input  wire logic [ADDR_W-1:0] peek_addr_i,
  output logic [INST_W-1:0]      peek_data_o
);

  // Program image covers the 256 bytes above PC_INIT.
  logic [INST_W-1:0] image [64];
  logic [63:0]       loaded;
  int unsigned       read_count [64];
  int unsigned       wait_cnt;
  logic              busy;

  initial begin
    loaded   = '0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    busy     = 1'b0;
    wait_cnt = 0;
    for (int i = 0; i < 64; i++) begin
      read_count[i] = 0;
    end
  end

  task automatic preload(input logic [ADDR_W-1:0] addr, input logic [INST_W-1:0] word);
    image[addr[7:2]]  = word;
    loaded[addr[7:2]] = 1'b1;
  endtask

  // Filler is an addi whose immediate folds the whole address.
  function automatic logic [INST_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
    logic [11:0] imm;
    imm = addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]};
    if (addr[ADDR_W-1:8] == PC_INIT[ADDR_W-1:8] && loaded[addr[7:2]]) begin
      return image[addr[7:2]];
    end
    return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
  endfunction

  always_comb peek_data_o = word_at(peek_addr_i);

  // One read at a time, answered 1 to 4 cycles after it is seen.
  always @(posedge clk) begin
    #1;
    if (rst) begin
      rvalid_o = 1'b0;
      busy     = 1'b0;
    end else if (rvalid_o) begin
      rvalid_o = 1'b0;
    end else if (arvalid_i && !busy) begin
      busy     = 1'b1;
      wait_cnt = $urandom % 4;
      read_count[araddr_i[7:2]] = read_count[araddr_i[7:2]] + 1;
    end else if (busy && wait_cnt == 0) begin
      rvalid_o = 1'b1;
      rdata_o  = word_at(araddr_i);
      busy     = 1'b0;
    end else if (busy) begin
      wait_cnt = wait_cnt - 1;
    end
  end

endmodule

`default_nettype wire

//--- tb_fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_unit
  import fetch_pkg::*;
();

  localparam int unsigned SEED           = 32'hedd5;
  localparam int unsigned REFILL_CYCLES  = 11;
  localparam int unsigned N_REFILLS      = 10;
  localparam int unsigned STALL_CYCLES   = 6;
  localparam int unsigned N_STALLS       = 8;
  localparam int unsigned TIMEOUT_CYCLES =
    20 * (N_REFILLS * REFILL_CYCLES + N_STALLS * STALL_CYCLES);
  localparam logic [INST_W-1:0] INST_LW  = 32'h0000_2103;
  localparam logic [INST_W-1:0] INST_BEQ = 32'h0000_0063;

  logic clk;
  logic rst;
  logic [ADDR_W-1:0] araddr;
  logic arvalid;
  logic [INST_W-1:0] rdata;
  logic rvalid;
  logic busy;
  logic [ADDR_W-1:0] npc;
  logic pc_change;
  logic pc_retire;
  logic prev_valid;
  logic next_ready;
  logic valid;
  logic ready;
  logic [INST_W-1:0] inst;
  logic [ADDR_W-1:0] pc;
  logic bad_spec;

  // Reference state of the fetch rules.
  logic [ADDR_W-1:0] exp_pc;
  logic [INST_W-1:0] exp_inst;
  opcode_e exp_op;
  logic exp_branch;
  logic exp_load;
  logic predicted;
  logic accept;
  logic waiting;
  logic wait_load;
  logic btb_v;
  logic [ADDR_W-1:0] btb_pc;
  logic [ADDR_W-1:0] btb_tgt;
  logic spec;
  logic [ADDR_W-1:0] spec_tgt;
  logic first_read_seen;
  logic expect_no_reads;
  logic check_refetch;
  int unsigned snap_lo;
  int unsigned snap_hi;
  int error_count = 0;
  int errors_at_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int unsigned cycle_count = 0;

  fetch_unit u_dut (
    .clk               (clk),
    .rst               (rst),
    .ifu_araddr_o      (araddr),
    .ifu_arvalid_o     (arvalid),
    .ifu_rdata_i       (rdata),
    .ifu_rvalid_i      (rvalid),
    .ifu_busy_o        (busy),
    .npc_i             (npc),
    .pc_change_i       (pc_change),
    .pc_retire_i       (pc_retire),
    .prev_valid_i      (prev_valid),
    .next_ready_i      (next_ready),
    .valid_o           (valid),
    .ready_o           (ready),
    .inst_o            (inst),
    .pc_o              (pc),
    .bad_speculation_o (bad_spec)
  );

  tb_mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .peek_addr_i (exp_pc),
    .peek_data_o (exp_inst)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  assign accept     = valid && next_ready;
  assign exp_op     = opcode_e'(exp_inst[6:0]);
  assign exp_branch = exp_op inside {OP_BRANCH, OP_JAL, OP_JALR, OP_SYSTEM};
  assign exp_load   = (exp_op == OP_LOAD);
  assign predicted  = btb_v && (btb_pc == exp_pc) && !spec;

  always @(posedge clk) begin
    if (rst) begin
      exp_pc    <= PC_INIT;
      waiting   <= 1'b0;
      wait_load <= 1'b0;
      btb_v     <= 1'b0;
      spec      <= 1'b0;
      first_read_seen <= 1'b0;
    end else begin
      if (arvalid) begin
        first_read_seen <= 1'b1;
      end
      if (waiting && !wait_load && prev_valid && pc_change) begin
        btb_v   <= 1'b1;
        btb_pc  <= exp_pc;
        btb_tgt <= npc;
      end
      if (accept && exp_branch && predicted) begin
        spec     <= 1'b1;
        spec_tgt <= btb_tgt;
      end else if (prev_valid) begin
        spec <= 1'b0;
      end
      if ((prev_valid && spec && npc != spec_tgt) ||
          (waiting && prev_valid && (wait_load ? pc_retire : pc_change))) begin
        exp_pc  <= npc;
        waiting <= 1'b0;
      end else if (accept) begin
        if (exp_branch && predicted) begin
          exp_pc <= btb_tgt;
        end else if (exp_branch || exp_load) begin
          waiting   <= 1'b1;
          wait_load <= exp_load;
        end else begin
          exp_pc <= exp_pc + 32'd4;
        end
      end
    end
  end

  a_reset_state : assert property (@(posedge clk) $fell(rst) |->
    !valid && !arvalid && !busy && !bad_spec && pc == PC_INIT)
    else begin
      error_count++;
      $display("error: outputs not idle after reset, pc_o %h", $sampled(pc));
    end

  a_first_read : assert property (@(posedge clk) disable iff (rst)
    arvalid && !first_read_seen |-> araddr == PC_INIT)
    else begin
      error_count++;
      $display("error: ifu_araddr_o %h expected %h", $sampled(araddr), PC_INIT);
    end

  a_pc : assert property (@(posedge clk) disable iff (rst) valid |-> pc == exp_pc)
    else begin
      error_count++;
      $display("error: pc_o %h expected %h", $sampled(pc), $sampled(exp_pc));
    end

  a_inst : assert property (@(posedge clk) disable iff (rst) valid |-> inst == exp_inst)
    else begin
      error_count++;
      $display("error: inst_o %h expected %h", $sampled(inst), $sampled(exp_inst));
    end

  a_ready : assert property (@(posedge clk) disable iff (rst) ready == !valid)
    else begin
      error_count++;
      $display("error: ready_o %h expected %h", $sampled(ready), !$sampled(valid));
    end

  a_hold : assert property (@(posedge clk) disable iff (rst)
    valid && !next_ready && !prev_valid |=> valid && $stable(pc) && $stable(inst))
    else begin
      error_count++;
      $display("error: output changed under back-pressure, pc_o %h", $sampled(pc));
    end

  a_stall : assert property (@(posedge clk) disable iff (rst) waiting |-> !valid)
    else begin
      error_count++;
      $display("error: valid_o %h expected 0 while stalled", $sampled(valid));
    end

  a_second_word : assert property (@(posedge clk) disable iff (rst)
    arvalid && rvalid && !araddr[2] |-> ##2 arvalid && araddr == $past(araddr, 2) + 32'd4)
    else begin
      error_count++;
      $display("error: second read of a line missing or misaddressed, ifu_araddr_o %h",
               $sampled(araddr));
    end

  // Busy covers both reads, the gap after the first and the cycle after the second.
  a_busy : assert property (@(posedge clk) disable iff (rst)
    busy == (arvalid || $past(arvalid && rvalid)))
    else begin
      error_count++;
      $display("error: ifu_busy_o %h expected %h", $sampled(busy), !$sampled(busy));
    end

  a_no_reads : assert property (@(posedge clk) disable iff (rst) expect_no_reads |-> !arvalid)
    else begin
      error_count++;
      $display("error: read of %h issued for a cached line", $sampled(araddr));
    end

  a_bad_spec : assert property (@(posedge clk) disable iff (rst)
    bad_spec == (prev_valid && spec && npc != spec_tgt))
    else begin
      error_count++;
      $display("error: bad_speculation_o %h expected %h", $sampled(bad_spec),
               !$sampled(bad_spec));
    end

  a_refetch : assert property (@(posedge clk) disable iff (rst) check_refetch |->
    u_mem.read_count[4] == snap_lo + 1 && u_mem.read_count[5] == snap_hi + 1)
    else begin
      error_count++;
      $display("error: line at %h was not read again after fence.i", PC_INIT + 32'h10);
    end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Returns just after the edge that accepts the instruction at target.
  task automatic accept_at(input logic [ADDR_W-1:0] target);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = valid && next_ready && (pc == target);
      @(posedge clk);
      #1;
      next_ready = ($urandom % 4) != 0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_backend(input logic [ADDR_W-1:0] next_pc, input logic change,
                                input logic retire);
    prev_valid = 1'b1;
    npc        = next_pc;
    pc_change  = change;
    pc_retire  = retire;
    @(posedge clk);
    #1;
    prev_valid = 1'b0;
    pc_change  = 1'b0;
    pc_retire  = 1'b0;
  endtask

  task automatic finish_test(input string name);
    if (error_count == errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errors_at_start);
    end
    errors_at_start = error_count;
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    npc = '0;
    pc_change = 1'b0;
    pc_retire = 1'b0;
    prev_valid = 1'b0;
    next_ready = 1'b0;
    expect_no_reads = 1'b0;
    check_refetch = 1'b0;
    #1;
    u_mem.preload(PC_INIT + 32'h1c, INST_LW);
    u_mem.preload(PC_INIT + 32'h44, INST_BEQ);
    u_mem.preload(PC_INIT + 32'h48, INST_LW);
    u_mem.preload(PC_INIT + 32'h80, INST_FENCE_I);
    u_mem.preload(PC_INIT + 32'h84, INST_LW);
    idle_cycles(8);
    rst = 1'b0;

    accept_at(PC_INIT);
    finish_test("reset");
    accept_at(PC_INIT + 32'h18);
    finish_test("sequential fetch");
    accept_at(PC_INIT + 32'h1c);
    idle_cycles(4);
    report_backend(PC_INIT, 1'b0, 1'b1);
    finish_test("load stall");

    // Same four lines again, all cached.
    expect_no_reads = 1'b1;
    accept_at(PC_INIT + 32'h1c);
    idle_cycles(2);
    expect_no_reads = 1'b0;
    report_backend(PC_INIT + 32'h40, 1'b0, 1'b1);
    finish_test("refill reuse");

    accept_at(PC_INIT + 32'h44);
    idle_cycles(3);
    report_backend(PC_INIT + 32'h40, 1'b1, 1'b0);
    accept_at(PC_INIT + 32'h44);
    report_backend(PC_INIT + 32'h48, 1'b1, 1'b0);
    accept_at(PC_INIT + 32'h48);
    idle_cycles(2);
    report_backend(PC_INIT + 32'h40, 1'b0, 1'b1);
    accept_at(PC_INIT + 32'h44);
    report_backend(PC_INIT + 32'h40, 1'b1, 1'b0);
    accept_at(PC_INIT + 32'h44);
    report_backend(PC_INIT + 32'h80, 1'b1, 1'b0);
    finish_test("branch speculation");

    snap_lo = u_mem.read_count[4];
    snap_hi = u_mem.read_count[5];
    accept_at(PC_INIT + 32'h80);
    accept_at(PC_INIT + 32'h84);
    idle_cycles(2);
    report_backend(PC_INIT + 32'h10, 1'b0, 1'b1);
    accept_at(PC_INIT + 32'h10);
    check_refetch = 1'b1;
    idle_cycles(1);
    check_refetch = 1'b0;
    next_ready = 1'b0;
    idle_cycles(2);
    finish_test("fence.i");

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_unit.f
fetch_pkg.sv
icache_store.sv
icache_refill.sv
fetch_btb.sv
fetch_ctrl.sv
fetch_unit.sv
tb_mem_model.sv
tb_fetch_unit.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - fetch_pkg.sv
  - icache_store.sv
  - icache_refill.sv
  - fetch_btb.sv
  - fetch_ctrl.sv
  - fetch_unit.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_fetch_unit.sv
